//--- flist.f
+incdir+include
logic/dispatch_pkg.sv
logic/op_classify.sv
logic/dispatch_limiter.sv
logic/rename_forward.sv
logic/alloc_stage.sv
logic/dispatch_top.sv
tests/dispatch_tb.sv

//--- include/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Lanes handled per dispatch bundle
`define DISPATCH_N 2

`define ARCH_REG_SZ 32
`define PHYS_REG_SZ 64

`define ROB_SZ 16
// Store queue depth is a power of two so that indices wrap naturally
`define LSQ_SZ 8

// Reservation station banks
`define RS_ALU_SZ 8
`define RS_MEM_SZ 4

`define XLEN 32

`endif

//--- logic/alloc_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module alloc_stage
    import dispatch_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  lane_cnt_t                               dispatch_count,
    input  logic      [`DISPATCH_N-1:0][`XLEN-1:0]  win_pc,
    input  arch_idx_t [`DISPATCH_N-1:0]             win_rd,
    input  logic      [`DISPATCH_N-1:0][`XLEN-1:0]  win_imm,
    input  logic      [`DISPATCH_N-1:0]             is_load,
    input  logic      [`DISPATCH_N-1:0]             is_store,
    input  rs_bank_t  [`DISPATCH_N-1:0]             lane_bank,
    input  phys_tag_t [`DISPATCH_N-1:0]             src1_tag,
    input  logic      [`DISPATCH_N-1:0]             src1_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]             src2_tag,
    input  logic      [`DISPATCH_N-1:0]             src2_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]             dest_tag,
    input  phys_tag_t [`DISPATCH_N-1:0]             prev_tag,
    input  rob_idx_t  [`DISPATCH_N-1:0]             rob_alloc_idxs,
    input  sq_idx_t   [`DISPATCH_N-1:0]             sq_alloc_idxs,
    input  sq_idx_t                                 sq_tail,
    input  logic                                    out_ready,
    output logic                                    alloc_ready,
    output logic                                    out_valid,
    output logic      [`DISPATCH_N-1:0]             out_lane_valid,
    output logic      [`DISPATCH_N-1:0][`XLEN-1:0]  out_pc,
    output arch_idx_t [`DISPATCH_N-1:0]             out_arch_rd,
    output phys_tag_t [`DISPATCH_N-1:0]             out_phys_rd,
    output phys_tag_t [`DISPATCH_N-1:0]             out_prev_phys,
    output phys_tag_t [`DISPATCH_N-1:0]             out_src1_tag,
    output logic      [`DISPATCH_N-1:0]             out_src1_ready,
    output phys_tag_t [`DISPATCH_N-1:0]             out_src2_tag,
    output logic      [`DISPATCH_N-1:0]             out_src2_ready,
    output logic      [`DISPATCH_N-1:0][`XLEN-1:0]  out_imm,
    output rob_idx_t  [`DISPATCH_N-1:0]             out_rob_idx,
    output rs_bank_t  [`DISPATCH_N-1:0]             out_bank,
    output logic      [`DISPATCH_N-1:0]             out_is_store,
    output sq_ref_u   [`DISPATCH_N-1:0]             out_sq_ref
);

    logic                   load;
    logic [`DISPATCH_N-1:0] lane_valid;
    sq_ref_u [`DISPATCH_N-1:0] lane_sq_ref;

    // Register empty or draining this cycle
    assign alloc_ready = !out_valid || out_ready;
    assign load        = (dispatch_count != '0) && alloc_ready;

    always_comb begin
        lane_cnt_t st_cnt;

        st_cnt = '0;
        for (int i = 0; i < `DISPATCH_N; i++) begin
            lane_valid[i]  = i < int'(dispatch_count);
            lane_sq_ref[i] = '0;

            // Store slots are handed out in store order rather than lane order
            if (is_store[i])
                lane_sq_ref[i].own_slot = sq_alloc_idxs[st_cnt];
            else if (is_load[i])
                lane_sq_ref[i].older_bound = sq_tail + sq_idx_t'(st_cnt);  // wraps at LSQ_SZ

            if (lane_valid[i] && is_store[i])
                st_cnt = st_cnt + lane_cnt_t'(1);
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_lane_valid <= '0;
        end else if (alloc_ready) begin
            out_valid      <= load;
            out_lane_valid <= load ? lane_valid : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_pc         <= win_pc;
            out_arch_rd    <= win_rd;
            out_phys_rd    <= dest_tag;
            out_prev_phys  <= prev_tag;
            out_src1_tag   <= src1_tag;
            out_src1_ready <= src1_ready;
            out_src2_tag   <= src2_tag;
            out_src2_ready <= src2_ready;
            out_imm        <= win_imm;
            out_rob_idx    <= rob_alloc_idxs;
            out_bank       <= lane_bank;
            out_is_store   <= is_store;
            out_sq_ref     <= lane_sq_ref;
        end
    end

    // A stalled bundle must not change under the consumer
    assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_lane_valid)
            && $stable(out_phys_rd) && $stable(out_rob_idx) && $stable(out_sq_ref)
            && $stable(out_pc))
        else $error("output bundle changed while stalled");

endmodule

`default_nettype wire

//--- logic/dispatch_limiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_limiter
    import dispatch_pkg::*;
(
    input  lane_cnt_t                            window_valid_count,
    input  logic      [`DISPATCH_N-1:0]          win_uses_rd,
    input  logic      [`DISPATCH_N-1:0]          is_load,
    input  logic      [`DISPATCH_N-1:0]          is_store,
    input  rs_bank_t  [`DISPATCH_N-1:0]          lane_bank,
    input  slot_cnt_t                            rob_free,
    input  logic      [$clog2(`PHYS_REG_SZ+1)-1:0] freelist_free,
    input  slot_cnt_t                            sq_free,
    input  slot_cnt_t                            rs_alu_free,
    input  slot_cnt_t                            rs_mem_free,
    input  logic                                 sq_has_pending_store,
    input  logic                                 alloc_ready,
    output lane_cnt_t                            dispatch_count
);

    always_comb begin
        lane_cnt_t count;
        slot_cnt_t rob_used;
        slot_cnt_t fl_used;
        slot_cnt_t sq_used;
        slot_cnt_t alu_used;
        slot_cnt_t mem_used;
        logic      stop;
        logic      store_seen;
        logic      lane_ok;

        count      = '0;
        rob_used   = '0;
        fl_used    = '0;
        sq_used    = '0;
        alu_used   = '0;
        mem_used   = '0;
        stop       = 1'b0;
        store_seen = 1'b0;

        for (int i = 0; i < `DISPATCH_N; i++) begin
            lane_ok = !stop && (i < int'(window_valid_count));

            // Loads wait until every older store has left the queue
            if (is_load[i] && (sq_has_pending_store || store_seen))
                lane_ok = 1'b0;
            if (rob_used >= rob_free)
                lane_ok = 1'b0;
            if (win_uses_rd[i] && (fl_used >= freelist_free))
                lane_ok = 1'b0;
            if (is_store[i] && (sq_used >= sq_free))
                lane_ok = 1'b0;
            if (lane_bank[i] == BANK_ALU ? (alu_used >= rs_alu_free) : (mem_used >= rs_mem_free))
                lane_ok = 1'b0;

            if (lane_ok) begin
                count    = count + lane_cnt_t'(1);
                rob_used = rob_used + slot_cnt_t'(1);
                if (win_uses_rd[i])
                    fl_used = fl_used + slot_cnt_t'(1);
                if (is_store[i]) begin
                    sq_used    = sq_used + slot_cnt_t'(1);
                    store_seen = 1'b1;
                end
                if (lane_bank[i] == BANK_ALU)
                    alu_used = alu_used + slot_cnt_t'(1);
                else
                    mem_used = mem_used + slot_cnt_t'(1);
            end else begin
                // In-order dispatch stops at the first blocked lane
                stop = 1'b1;
            end
        end

        dispatch_count = alloc_ready ? count : '0;
    end

    always_comb begin
        assert final (dispatch_count <= window_valid_count)
            else $error("dispatch_count %0d above window count %0d",
                        dispatch_count, window_valid_count);
    end

endmodule

`default_nettype wire

//--- logic/dispatch_pkg.sv
`default_nettype none

`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef logic [$clog2(`ARCH_REG_SZ)-1:0] arch_idx_t;
    typedef logic [$clog2(`PHYS_REG_SZ)-1:0] phys_tag_t;
    typedef logic [$clog2(`ROB_SZ)-1:0] rob_idx_t;
    typedef logic [$clog2(`LSQ_SZ)-1:0] sq_idx_t;

    // Free-slot count that holds 0 up to ROB_SZ
    typedef logic [$clog2(`ROB_SZ+1)-1:0] slot_cnt_t;

    // Number of lanes from 0 up to DISPATCH_N
    typedef logic [$clog2(`DISPATCH_N+1)-1:0] lane_cnt_t;

    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_LOAD_W  = 3'd1,
        OP_LOAD_B  = 3'd2,
        OP_STORE_W = 3'd3,
        OP_STORE_B = 3'd4,
        OP_JALR    = 3'd5
    } op_kind_t;

    typedef enum logic {
        BANK_ALU = 1'b0,
        BANK_MEM = 1'b1
    } rs_bank_t;

    // Store queue reference carried with a memory op
    // A store holds the slot it owns and a load holds the first slot younger than it
    typedef union packed {
        sq_idx_t own_slot;
        sq_idx_t older_bound;
    } sq_ref_u;

endpackage

`default_nettype wire

//--- logic/dispatch_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                                     clock,
    input  logic                                     rst_n,

    // Dispatch window
    input  arch_idx_t [`DISPATCH_N-1:0]              win_rs1,
    input  arch_idx_t [`DISPATCH_N-1:0]              win_rs2,
    input  arch_idx_t [`DISPATCH_N-1:0]              win_rd,
    input  logic      [`DISPATCH_N-1:0]              win_uses_rd,
    input  op_kind_t  [`DISPATCH_N-1:0]              win_op,
    input  logic      [`DISPATCH_N-1:0]              win_opb_rs2,
    input  logic      [`DISPATCH_N-1:0][`XLEN-1:0]   win_imm,
    input  logic      [`DISPATCH_N-1:0][`XLEN-1:0]   win_pc,
    input  lane_cnt_t                                window_valid_count,
    output lane_cnt_t                                dispatch_count,

    // Structural resources
    input  slot_cnt_t                                rob_free,
    input  logic      [$clog2(`PHYS_REG_SZ+1)-1:0]   freelist_free,
    input  slot_cnt_t                                sq_free,
    input  slot_cnt_t                                rs_alu_free,
    input  slot_cnt_t                                rs_mem_free,
    input  logic                                     sq_has_pending_store,
    input  rob_idx_t  [`DISPATCH_N-1:0]              rob_alloc_idxs,
    input  sq_idx_t   [`DISPATCH_N-1:0]              sq_alloc_idxs,
    input  sq_idx_t                                  sq_tail,

    // Map table
    output arch_idx_t [`DISPATCH_N-1:0]              map_rs1_addr,
    output arch_idx_t [`DISPATCH_N-1:0]              map_rs2_addr,
    output arch_idx_t [`DISPATCH_N-1:0]              map_rd_addr,
    input  phys_tag_t [`DISPATCH_N-1:0]              map_rs1_tag,
    input  logic      [`DISPATCH_N-1:0]              map_rs1_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]              map_rs2_tag,
    input  logic      [`DISPATCH_N-1:0]              map_rs2_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]              map_rd_tag,
    output logic      [`DISPATCH_N-1:0]              map_wr_valid,
    output arch_idx_t [`DISPATCH_N-1:0]              map_wr_addr,
    output phys_tag_t [`DISPATCH_N-1:0]              map_wr_tag,

    // Free list
    input  logic      [`DISPATCH_N-1:0][`PHYS_REG_SZ-1:0] granted_regs,
    output logic      [`DISPATCH_N-1:0]              free_alloc_valid,

    // Allocation bundle toward ROB and reservation stations
    input  logic                                     out_ready,
    output logic                                     out_valid,
    output logic      [`DISPATCH_N-1:0]              out_lane_valid,
    output logic      [`DISPATCH_N-1:0][`XLEN-1:0]   out_pc,
    output arch_idx_t [`DISPATCH_N-1:0]              out_arch_rd,
    output phys_tag_t [`DISPATCH_N-1:0]              out_phys_rd,
    output phys_tag_t [`DISPATCH_N-1:0]              out_prev_phys,
    output phys_tag_t [`DISPATCH_N-1:0]              out_src1_tag,
    output logic      [`DISPATCH_N-1:0]              out_src1_ready,
    output phys_tag_t [`DISPATCH_N-1:0]              out_src2_tag,
    output logic      [`DISPATCH_N-1:0]              out_src2_ready,
    output logic      [`DISPATCH_N-1:0][`XLEN-1:0]   out_imm,
    output rob_idx_t  [`DISPATCH_N-1:0]              out_rob_idx,
    output rs_bank_t  [`DISPATCH_N-1:0]              out_bank,
    output logic      [`DISPATCH_N-1:0]              out_is_store,
    output sq_ref_u   [`DISPATCH_N-1:0]              out_sq_ref
);

    logic      [`DISPATCH_N-1:0] is_load;
    logic      [`DISPATCH_N-1:0] is_store;
    rs_bank_t  [`DISPATCH_N-1:0] lane_bank;
    logic      [`DISPATCH_N-1:0] needs_rs2;
    logic                        alloc_ready;
    phys_tag_t [`DISPATCH_N-1:0] src1_tag;
    logic      [`DISPATCH_N-1:0] src1_ready;
    phys_tag_t [`DISPATCH_N-1:0] src2_tag;
    logic      [`DISPATCH_N-1:0] src2_ready;
    phys_tag_t [`DISPATCH_N-1:0] dest_tag;
    phys_tag_t [`DISPATCH_N-1:0] prev_tag;

    op_classify u_classify (.*);

    dispatch_limiter u_limiter (.*);

    rename_forward u_rename (.*);

    alloc_stage u_alloc (.*);

endmodule

`default_nettype wire

//--- logic/op_classify.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module op_classify
    import dispatch_pkg::*;
(
    input  op_kind_t [`DISPATCH_N-1:0] win_op,
    input  logic     [`DISPATCH_N-1:0] win_opb_rs2,
    output logic     [`DISPATCH_N-1:0] is_load,
    output logic     [`DISPATCH_N-1:0] is_store,
    output rs_bank_t [`DISPATCH_N-1:0] lane_bank,
    output logic     [`DISPATCH_N-1:0] needs_rs2
);

    always_comb begin
        for (int i = 0; i < `DISPATCH_N; i++) begin
            is_load[i]  = (win_op[i] == OP_LOAD_W) || (win_op[i] == OP_LOAD_B);
            is_store[i] = (win_op[i] == OP_STORE_W) || (win_op[i] == OP_STORE_B);

            // Memory ops share one bank and the jump goes with the ALU ops
            lane_bank[i] = (is_load[i] || is_store[i]) ? BANK_MEM : BANK_ALU;

            // A store reads its data through rs2
            needs_rs2[i] = win_opb_rs2[i] || is_store[i];
        end
    end

endmodule

`default_nettype wire

//--- logic/rename_forward.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module rename_forward
    import dispatch_pkg::*;
(
    input  lane_cnt_t                                    dispatch_count,
    input  arch_idx_t [`DISPATCH_N-1:0]                  win_rs1,
    input  arch_idx_t [`DISPATCH_N-1:0]                  win_rs2,
    input  arch_idx_t [`DISPATCH_N-1:0]                  win_rd,
    input  logic      [`DISPATCH_N-1:0]                  win_uses_rd,
    input  logic      [`DISPATCH_N-1:0]                  needs_rs2,
    input  phys_tag_t [`DISPATCH_N-1:0]                  map_rs1_tag,
    input  logic      [`DISPATCH_N-1:0]                  map_rs1_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]                  map_rs2_tag,
    input  logic      [`DISPATCH_N-1:0]                  map_rs2_ready,
    input  phys_tag_t [`DISPATCH_N-1:0]                  map_rd_tag,
    input  logic      [`DISPATCH_N-1:0][`PHYS_REG_SZ-1:0] granted_regs,
    output arch_idx_t [`DISPATCH_N-1:0]                  map_rs1_addr,
    output arch_idx_t [`DISPATCH_N-1:0]                  map_rs2_addr,
    output arch_idx_t [`DISPATCH_N-1:0]                  map_rd_addr,
    output logic      [`DISPATCH_N-1:0]                  map_wr_valid,
    output arch_idx_t [`DISPATCH_N-1:0]                  map_wr_addr,
    output phys_tag_t [`DISPATCH_N-1:0]                  map_wr_tag,
    output logic      [`DISPATCH_N-1:0]                  free_alloc_valid,
    output phys_tag_t [`DISPATCH_N-1:0]                  src1_tag,
    output logic      [`DISPATCH_N-1:0]                  src1_ready,
    output phys_tag_t [`DISPATCH_N-1:0]                  src2_tag,
    output logic      [`DISPATCH_N-1:0]                  src2_ready,
    output phys_tag_t [`DISPATCH_N-1:0]                  dest_tag,
    output phys_tag_t [`DISPATCH_N-1:0]                  prev_tag
);

    assign map_rs1_addr = win_rs1;
    assign map_rs2_addr = win_rs2;
    assign map_rd_addr  = win_rd;

    always_comb begin
        for (int i = 0; i < `DISPATCH_N; i++) begin
            // One-hot grant to tag as the OR of the set bit positions
            dest_tag[i] = '0;
            for (int k = 0; k < `PHYS_REG_SZ; k++) begin
                if (granted_regs[i][k])
                    dest_tag[i] = dest_tag[i] | phys_tag_t'(k);
            end

            src1_tag[i]   = map_rs1_tag[i];
            src1_ready[i] = map_rs1_ready[i];
            src2_tag[i]   = map_rs2_tag[i];
            src2_ready[i] = map_rs2_ready[i] || !needs_rs2[i];
            prev_tag[i]   = map_rd_tag[i];

            // Older lanes in the bundle are not in the map table yet
            // The youngest older writer wins since later lanes overwrite
            for (int j = 0; j < i; j++) begin
                if ((j < int'(dispatch_count)) && win_uses_rd[j]) begin
                    if (win_rd[j] == win_rs1[i]) begin
                        src1_tag[i]   = dest_tag[j];
                        src1_ready[i] = 1'b0;
                    end
                    if (needs_rs2[i] && (win_rd[j] == win_rs2[i])) begin
                        src2_tag[i]   = dest_tag[j];
                        src2_ready[i] = 1'b0;
                    end
                    // Same rd twice in one bundle frees the older lane's tag
                    if (win_rd[j] == win_rd[i])
                        prev_tag[i] = dest_tag[j];
                end
            end

            map_wr_valid[i]     = (i < int'(dispatch_count)) && win_uses_rd[i];
            map_wr_addr[i]      = win_rd[i];
            map_wr_tag[i]       = dest_tag[i];
            free_alloc_valid[i] = map_wr_valid[i];
        end
    end

    always_comb begin
        for (int i = 0; i < `DISPATCH_N; i++) begin
            assert final (!free_alloc_valid[i] || $onehot(granted_regs[i]))
                else $error("lane %0d grant is not one-hot", i);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb -f flist.f \
    -o dispatch_sim > build.log 2>&1 && ./obj_dir/dispatch_sim > sim.log 2>&1
cat sim.log 2>/dev/null || echo "No simulation log, see build.log"
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation gave no result"; exit 1; }
echo "Simulation passed"

//--- tests/dispatch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_tb
    import dispatch_pkg::*;
();

    localparam phys_tag_t GRANT0 = phys_tag_t'(40);
    localparam phys_tag_t GRANT1 = phys_tag_t'(41);
    localparam logic [`PHYS_REG_SZ-1:0] ONE_HOT_BASE = 1;
    localparam int WAIT_LIMIT = 20;

    logic clock = 1'b0;
    logic rst_n;
    int   seed = 32'haadf3fac;
    logic [`ARCH_REG_SZ-1:0] not_ready_mask;

    arch_idx_t [`DISPATCH_N-1:0] win_rs1, win_rs2, win_rd;
    logic      [`DISPATCH_N-1:0] win_uses_rd, win_opb_rs2;
    op_kind_t  [`DISPATCH_N-1:0] win_op;
    logic      [`DISPATCH_N-1:0][`XLEN-1:0] win_imm, win_pc;
    lane_cnt_t window_valid_count, dispatch_count;
    slot_cnt_t rob_free, sq_free, rs_alu_free, rs_mem_free;
    logic      [$clog2(`PHYS_REG_SZ+1)-1:0] freelist_free;
    logic      sq_has_pending_store;
    rob_idx_t  [`DISPATCH_N-1:0] rob_alloc_idxs;
    sq_idx_t   [`DISPATCH_N-1:0] sq_alloc_idxs;
    sq_idx_t   sq_tail;
    arch_idx_t [`DISPATCH_N-1:0] map_rs1_addr, map_rs2_addr, map_rd_addr, map_wr_addr;
    phys_tag_t [`DISPATCH_N-1:0] map_rs1_tag, map_rs2_tag, map_rd_tag, map_wr_tag;
    logic      [`DISPATCH_N-1:0] map_rs1_ready, map_rs2_ready, map_wr_valid, free_alloc_valid;
    logic      [`DISPATCH_N-1:0][`PHYS_REG_SZ-1:0] granted_regs;
    logic      out_ready, out_valid;
    logic      [`DISPATCH_N-1:0] out_lane_valid, out_src1_ready, out_src2_ready, out_is_store;
    logic      [`DISPATCH_N-1:0][`XLEN-1:0] out_pc, out_imm;
    arch_idx_t [`DISPATCH_N-1:0] out_arch_rd;
    phys_tag_t [`DISPATCH_N-1:0] out_phys_rd, out_prev_phys, out_src1_tag, out_src2_tag;
    rob_idx_t  [`DISPATCH_N-1:0] out_rob_idx;
    rs_bank_t  [`DISPATCH_N-1:0] out_bank;
    sq_ref_u   [`DISPATCH_N-1:0] out_sq_ref;

    dispatch_top UUT (.*);

    always #2 clock = ~clock;

    // Map table model where register r lives in tag r
    always_comb begin
        for (int i = 0; i < `DISPATCH_N; i++) begin
            map_rs1_tag[i]   = phys_tag_t'(map_rs1_addr[i]);
            map_rs1_ready[i] = !not_ready_mask[map_rs1_addr[i]];
            map_rs2_tag[i]   = phys_tag_t'(map_rs2_addr[i]);
            map_rs2_ready[i] = !not_ready_mask[map_rs2_addr[i]];
            map_rd_tag[i]    = phys_tag_t'(map_rd_addr[i]);
        end
    end

    // Free list model with fixed grants per lane
    assign granted_regs[0] = ONE_HOT_BASE << GRANT0;
    assign granted_regs[1] = ONE_HOT_BASE << GRANT1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic tag_is(input phys_tag_t got, input phys_tag_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic count_is(input lane_cnt_t got, input lane_cnt_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic sq_ref_is(input sq_ref_u got, input sq_ref_u exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic arch_is(input arch_idx_t got, input arch_idx_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic rob_is(input rob_idx_t got, input rob_idx_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic word_is(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                           input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic bit_is(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic set_lane(input int lane, input op_kind_t op, input arch_idx_t rs1,
                            input arch_idx_t rs2, input arch_idx_t rd, input logic uses_rd,
                            input logic opb_rs2);
        win_op[lane]      = op;
        win_rs1[lane]     = rs1;
        win_rs2[lane]     = rs2;
        win_rd[lane]      = rd;
        win_uses_rd[lane] = uses_rd;
        win_opb_rs2[lane] = opb_rs2;
        win_pc[lane]      = 32'h0000_1000 + 32'(4 * lane);
        win_imm[lane]     = $random(seed);
    endtask

    task automatic free_all();
        rob_free             = slot_cnt_t'(`ROB_SZ);
        freelist_free        = 7'd24;
        sq_free              = slot_cnt_t'(`LSQ_SZ);
        rs_alu_free          = slot_cnt_t'(`RS_ALU_SZ);
        rs_mem_free          = slot_cnt_t'(`RS_MEM_SZ);
        sq_has_pending_store = 1'b0;
        rob_alloc_idxs[0]    = rob_idx_t'(3);
        rob_alloc_idxs[1]    = rob_idx_t'(4);
        sq_alloc_idxs[0]     = sq_idx_t'(2);
        sq_alloc_idxs[1]     = sq_idx_t'(3);
        sq_tail              = sq_idx_t'(5);
        out_ready            = 1'b1;
    endtask

    task automatic to_drive_slot();
        @(posedge clock);
        #1;
    endtask

    // The window buffer drops the dispatched lanes on the edge
    task automatic retire_window();
        to_drive_slot();
        window_valid_count = '0;
    endtask

    task automatic wait_out_valid(input logic level);
        int n;
        for (n = 0; n < WAIT_LIMIT && out_valid !== level; n++)
            to_drive_slot();
        if (out_valid !== level)
            abort_run($sformatf("Timed out waiting for out_valid to become %b", level));
    endtask

    task automatic reset_and_basic();
        bit_is(out_valid, 1'b0, "out_valid after reset");
        bit_is(out_lane_valid[0], 1'b0, "lane 0 valid after reset");
        bit_is(out_lane_valid[1], 1'b0, "lane 1 valid after reset");
        to_drive_slot();
        free_all();
        set_lane(0, OP_ALU, 1, 3, 5, 1'b1, 1'b1);
        set_lane(1, OP_ALU, 2, 4, 6, 1'b1, 1'b1);
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd2, "basic dispatch count");
        bit_is(free_alloc_valid[1], 1'b1, "lane 1 free-list request");
        arch_is(map_wr_addr[0], arch_idx_t'(5), "lane 0 map write addr");
        arch_is(map_wr_addr[1], arch_idx_t'(6), "lane 1 map write addr");
        retire_window();
        wait_out_valid(1'b1);
        tag_is(out_phys_rd[0], GRANT0, "lane 0 phys rd");
        tag_is(out_phys_rd[1], GRANT1, "lane 1 phys rd");
        tag_is(out_prev_phys[0], 6'd5, "lane 0 prev phys");
        tag_is(out_prev_phys[1], 6'd6, "lane 1 prev phys");
        tag_is(out_src1_tag[1], 6'd2, "lane 1 src1 tag");
        bit_is(out_src1_ready[0], !not_ready_mask[1], "lane 0 src1 ready");
        bit_is(out_src1_ready[1], !not_ready_mask[2], "lane 1 src1 ready");
        bit_is(out_src2_ready[1], !not_ready_mask[4], "lane 1 src2 ready");
        arch_is(out_arch_rd[0], arch_idx_t'(5), "lane 0 arch rd");
        arch_is(out_arch_rd[1], arch_idx_t'(6), "lane 1 arch rd");
        word_is(out_pc[1], 32'h0000_1004, "lane 1 pc");
        word_is(out_imm[0], win_imm[0], "lane 0 imm");
        word_is(out_imm[1], win_imm[1], "lane 1 imm");
        rob_is(out_rob_idx[0], rob_idx_t'(3), "lane 0 rob index");
        rob_is(out_rob_idx[1], rob_idx_t'(4), "lane 1 rob index");
        wait_out_valid(1'b0);
    endtask

    task automatic bundle_forwarding();
        to_drive_slot();
        free_all();
        set_lane(0, OP_ALU, 1, 3, 7, 1'b1, 1'b1);
        set_lane(1, OP_ALU, 7, 7, 8, 1'b1, 1'b1);
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd2, "forwarding dispatch count");
        tag_is(map_wr_tag[0], GRANT0, "lane 0 map write tag");
        tag_is(map_wr_tag[1], GRANT1, "lane 1 map write tag");
        retire_window();
        wait_out_valid(1'b1);
        tag_is(out_src1_tag[1], GRANT0, "forwarded src1 tag");
        bit_is(out_src1_ready[1], 1'b0, "forwarded src1 ready");
        tag_is(out_src2_tag[1], GRANT0, "forwarded src2 tag");
        bit_is(out_src2_ready[1], 1'b0, "forwarded src2 ready");
        wait_out_valid(1'b0);

        // With an immediate operand B rs2 is not a real source
        // Register 7 reads as not ready in the map for this bundle
        to_drive_slot();
        not_ready_mask[7] = 1'b1;
        set_lane(0, OP_ALU, 1, 3, 7, 1'b1, 1'b1);
        set_lane(1, OP_ALU, 7, 7, 8, 1'b1, 1'b0);
        window_valid_count = 2'd2;
        retire_window();
        wait_out_valid(1'b1);
        tag_is(out_src1_tag[1], GRANT0, "src1 tag with imm operand");
        tag_is(out_src2_tag[1], 6'd7, "unused src2 tag");
        bit_is(out_src2_ready[1], 1'b1, "unused src2 ready");
        not_ready_mask[7] = 1'b0;
        wait_out_valid(1'b0);
    endtask

    task automatic structural_hazards();
        to_drive_slot();
        free_all();
        rs_alu_free = slot_cnt_t'(1);
        set_lane(0, OP_ALU, 1, 3, 5, 1'b1, 1'b0);
        set_lane(1, OP_ALU, 2, 4, 6, 1'b1, 1'b0);
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd1, "count with one ALU entry");
        retire_window();
        wait_out_valid(1'b1);
        bit_is(out_lane_valid[0], 1'b1, "lane 0 valid with one ALU entry");
        bit_is(out_lane_valid[1], 1'b0, "lane 1 valid with one ALU entry");
        wait_out_valid(1'b0);

        to_drive_slot();
        free_all();
        rob_free = '0;
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd0, "count with full ROB");
        bit_is(map_wr_valid[0], 1'b0, "map write with full ROB");

        to_drive_slot();
        free_all();
        freelist_free = '0;
        set_lane(0, OP_ALU, 1, 3, 0, 1'b0, 1'b0);
        set_lane(1, OP_ALU, 1, 3, 9, 1'b1, 1'b0);
        #1;
        count_is(dispatch_count, 2'd1, "count with empty free list");
        bit_is(free_alloc_valid[0], 1'b0, "free-list request without rd");
        retire_window();
        wait_out_valid(1'b1);
        wait_out_valid(1'b0);
    endtask

    task automatic memory_ordering();
        sq_ref_u exp_ref;

        to_drive_slot();
        free_all();
        set_lane(0, OP_STORE_W, 1, 3, 0, 1'b0, 1'b0);
        set_lane(1, OP_LOAD_W, 4, 0, 9, 1'b1, 1'b0);
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd1, "store then load count");
        exp_ref          = '0;
        exp_ref.own_slot = sq_alloc_idxs[0];
        retire_window();
        wait_out_valid(1'b1);
        bit_is(out_is_store[0], 1'b1, "store flag");
        bit_is(out_bank[0] == BANK_MEM, 1'b1, "store bank is memory");
        sq_ref_is(out_sq_ref[0], exp_ref, "store own slot");
        wait_out_valid(1'b0);

        to_drive_slot();
        free_all();
        sq_has_pending_store = 1'b1;
        set_lane(0, OP_LOAD_B, 4, 0, 9, 1'b1, 1'b0);
        window_valid_count = 2'd1;
        #1;
        count_is(dispatch_count, 2'd0, "load behind pending store");

        to_drive_slot();
        sq_has_pending_store = 1'b0;
        sq_tail              = sq_idx_t'(6);
        #1;
        count_is(dispatch_count, 2'd1, "load with empty store queue");
        exp_ref             = '0;
        exp_ref.older_bound = sq_tail;
        retire_window();
        wait_out_valid(1'b1);
        bit_is(out_is_store[0], 1'b0, "load store flag");
        sq_ref_is(out_sq_ref[0], exp_ref, "load older bound");
        wait_out_valid(1'b0);
    endtask

    task automatic back_pressure();
        to_drive_slot();
        free_all();
        out_ready = 1'b0;
        set_lane(0, OP_ALU, 1, 3, 10, 1'b1, 1'b1);
        set_lane(1, OP_ALU, 2, 4, 11, 1'b1, 1'b1);
        window_valid_count = 2'd2;
        #1;
        count_is(dispatch_count, 2'd2, "first bundle count");
        to_drive_slot();
        set_lane(0, OP_ALU, 1, 3, 12, 1'b1, 1'b1);
        set_lane(1, OP_ALU, 2, 4, 13, 1'b1, 1'b1);
        wait_out_valid(1'b1);
        for (int c = 0; c < 12; c++) begin
            #1;
            count_is(dispatch_count, 2'd0, "count while stalled");
            bit_is(map_wr_valid[0] | map_wr_valid[1], 1'b0, "map write while stalled");
            bit_is(free_alloc_valid[0] | free_alloc_valid[1], 1'b0, "free-list request stalled");
            bit_is(out_valid, 1'b1, "out_valid while stalled");
            tag_is(out_prev_phys[0], 6'd10, "held lane 0 prev phys");
            tag_is(out_prev_phys[1], 6'd11, "held lane 1 prev phys");
            to_drive_slot();
        end
        out_ready = 1'b1;
        #1;
        count_is(dispatch_count, 2'd2, "count when draining");
        retire_window();
        bit_is(out_valid, 1'b1, "out_valid after transfer");
        tag_is(out_prev_phys[0], 6'd12, "next lane 0 prev phys");
        tag_is(out_prev_phys[1], 6'd13, "next lane 1 prev phys");
        wait_out_valid(1'b0);
    endtask

    initial begin
        rst_n              = 1'b0;
        not_ready_mask     = 32'h0000_0004;
        window_valid_count = '0;
        free_all();
        set_lane(0, OP_ALU, 0, 0, 0, 1'b0, 1'b0);
        set_lane(1, OP_ALU, 0, 0, 0, 1'b0, 1'b0);
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;

        reset_and_basic();
        bundle_forwarding();
        structural_hazards();
        memory_ordering();
        back_pressure();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
